// ==== Makefile ====
# Verilator build and run for the Hack computer testbench

VERILATOR ?= verilator
TOP ?= hack_computer_tb
FILELIST ?= hack_computer.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal

BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard common/*.svh bench/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG); \
	if grep -q "TEST RESULT: FAIL" $(LOG) || ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/hack_model.svh ====
`ifndef HACK_MODEL_SVH
`define HACK_MODEL_SVH

// Architectural state of the reference model
hack_word_t model_pc;
hack_word_t model_a;
hack_word_t model_d;
hack_word_t model_mem [1 << `HACK_RAM_ADDR_BITS];
bit model_known [1 << `HACK_RAM_ADDR_BITS];

// zx nx zy ny f no, applied in that order
function automatic hack_word_t alu_rule(input hack_word_t x, input hack_word_t y,
	input hack_comp_t c);
	hack_word_t xs;
	hack_word_t ys;
	hack_word_t r;
	xs = c[5] ? 16'h0000 : x;
	if (c[4])
		xs = ~xs;
	ys = c[3] ? 16'h0000 : y;
	if (c[2])
		ys = ~ys;
	if (c[1])
		r = xs + ys;
	else
		r = xs & ys;
	if (c[0])
		r = ~r;
	return r;
endfunction

// Jump code bits pick less, equal and greater from high to low
function automatic logic jump_rule(input hack_jump_t j, input hack_word_t r);
	logic zero;
	logic neg;
	zero = (r == 16'h0000);
	neg = r[15];
	return (j[2] && neg) || (j[1] && zero) || (j[0] && !zero && !neg);
endfunction

// ALU result of a C-instruction from the current state
function automatic hack_word_t expected_alu(input hack_word_t instr);
	hack_word_t y;
	y = instr[12] ? model_mem[model_a[`HACK_RAM_ADDR_BITS-1:0]] : model_a;
	return alu_rule(model_d, y, instr[11:6]);
endfunction

task automatic reset_model();
	model_pc = 16'h0000;
	model_a = 16'h0000;
	model_d = 16'h0000;
endtask

task automatic init_model();
	for (int i = 0; i < (1 << `HACK_RAM_ADDR_BITS); i++) begin
		model_known[i] = 1'b0;
	end
	reset_model();
endtask

// State after the next rising edge with old A as jump target and RAM address
task automatic step_model(input hack_word_t instr);
	hack_word_t r;
	hack_ram_addr_t idx;
	if (!instr[15]) begin
		model_pc = model_pc + 16'd1;
		model_a = {1'b0, instr[14:0]};
	end else begin
		idx = model_a[`HACK_RAM_ADDR_BITS-1:0];
		r = expected_alu(instr);
		model_pc = jump_rule(instr[2:0], r) ? model_a : model_pc + 16'd1;
		if (instr[3]) begin
			model_mem[idx] = r;
			model_known[idx] = 1'b1;
		end
		if (instr[4])
			model_d = r;
		if (instr[5])
			model_a = r;
	end
endtask

`endif

// ==== bench/hack_computer_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hack_settings.svh"

module hack_computer_tb;

	import hack_pkg::*;

	localparam int CLOCK_PERIOD = 10;
	localparam int RESET_CYCLES = 8;
	localparam int PRELOAD_WORDS = 32;
	localparam int DIRECTED_COUNT = 9;
	localparam int PHASE1_COUNT = 2000;
	localparam int PHASE2_COUNT = 1000;
	localparam int TOTAL_CYCLES = 2 * RESET_CYCLES + 4 * PRELOAD_WORDS + DIRECTED_COUNT
		+ PHASE1_COUNT + PHASE2_COUNT;

	// A-instruction whose comp field computes zero
	localparam hack_word_t IDLE_INSTR = 16'h0A80;
	localparam hack_word_t D_FROM_A = 16'hEC10;
	localparam hack_word_t M_FROM_D = 16'hE308;

	// Wrapped reads and AMD=D+1
	localparam hack_word_t DIRECTED [DIRECTED_COUNT] = '{16'h0005, 16'hFC10, 16'hE7F8,
		16'h0805, 16'hFC10, 16'h0007, 16'hE308, 16'h1007, 16'hFC10};

	logic clock;
	logic rst_n;
	hack_word_t instruction;
	hack_word_t pc;
	hack_word_t out_m;
	hack_word_t address_m;
	logic write_m;

	integer seed = 80;
	int errors = 0;
	int checks = 0;
	// Indexed by jump code then taken
	bit jump_seen [8][2];

	`include "hack_model.svh"

	hack_computer uut (
		.clock(clock),
		.rst_n(rst_n),
		.instruction(instruction),
		.pc(pc),
		.out_m(out_m),
		.write_m(write_m),
		.address_m(address_m)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(2 * TOTAL_CYCLES * CLOCK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", 2 * TOTAL_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	////////////////////
	// Helpers
	////////////////////
	task automatic check_value(input string name, input hack_word_t observed,
		input hack_word_t expected);
		checks++;
		if (observed !== expected) begin
			errors++;
			$display("CHECK FAILED %s observed %h expected %h at %0t", name, observed,
				expected, $time);
		end
	endtask

	function automatic hack_word_t random_instruction();
		logic [31:0] draw;
		logic [31:0] fields;
		hack_word_t instr;
		draw = $random(seed);
		fields = $random(seed);
		if (draw % 100 < 40) begin
			// Preloaded window with aliases above 2047 from bits 12:11
			instr = {3'b000, fields[6:5], 6'b000000, fields[4:0]};
		end else begin
			instr = {3'b111, fields[12:0]};
			// Read only words that hold a known value
			if (!model_known[model_a[`HACK_RAM_ADDR_BITS-1:0]])
				instr[12] = 1'b0;
		end
		return instr;
	endfunction

	// Present one instruction and check outputs mid cycle before the model advances
	task automatic run_instruction(input hack_word_t instr);
		hack_word_t exp_out;
		logic exp_write;
		logic taken;
		@(posedge clock);
		rst_n <= 1'b1;
		instruction <= instr;
		@(negedge clock);
		exp_write = instr[15] && instr[3];
		exp_out = exp_write ? expected_alu(instr) : 16'h0000;
		check_value("pc", pc, model_pc);
		check_value("address_m", address_m, model_a);
		check_value("write_m", hack_word_t'(write_m), hack_word_t'(exp_write));
		check_value("out_m", out_m, exp_out);
		if (instr[15]) begin
			taken = jump_rule(instr[2:0], expected_alu(instr));
			jump_seen[instr[2:0]][taken] = 1'b1;
		end
		step_model(instr);
	endtask

	task automatic drive_reset(input bit with_writes);
		hack_word_t instr;
		for (int i = 0; i < RESET_CYCLES; i++) begin
			instr = IDLE_INSTR;
			// C-instruction with dest M and a=0 to try a write under reset
			if (with_writes)
				instr = (random_instruction() | 16'hE008) & 16'hEFFF;
			@(posedge clock);
			rst_n <= 1'b0;
			instruction <= instr;
			@(negedge clock);
			check_value("write_m", hack_word_t'(write_m), 16'h0000);
			check_value("out_m", out_m, 16'h0000);
			if (i == 0) begin
				// First edge still runs the instruction before reset
				check_value("pc", pc, model_pc);
				check_value("address_m", address_m, model_a);
			end else begin
				check_value("pc", pc, 16'h0000);
				check_value("address_m", address_m, 16'h0000);
			end
		end
		reset_model();
	endtask

	task automatic preload_memory();
		hack_word_t value;
		for (int addr = 0; addr < PRELOAD_WORDS; addr++) begin
			value = hack_word_t'($random(seed)) & 16'h7FFF;
			run_instruction(value);
			run_instruction(D_FROM_A);
			run_instruction(hack_word_t'(addr));
			run_instruction(M_FROM_D);
		end
	endtask

	task automatic check_jump_coverage();
		for (int code = 0; code < 8; code++) begin
			if (code != 7 && !jump_seen[code][0]) begin
				errors++;
				$display("Jump code %0d was never seen with the jump not taken", code);
			end
			if (code != 0 && !jump_seen[code][1]) begin
				errors++;
				$display("Jump code %0d was never seen with the jump taken", code);
			end
		end
	endtask

	////////////////////
	// Test sequence
	////////////////////
	initial begin
		rst_n = 1'b0;
		instruction = IDLE_INSTR;
		init_model();
		drive_reset(1'b0);
		preload_memory();
		for (int i = 0; i < DIRECTED_COUNT; i++) begin
			run_instruction(DIRECTED[i]);
		end
		repeat (PHASE1_COUNT) run_instruction(random_instruction());
		drive_reset(1'b1);
		repeat (PHASE2_COUNT) run_instruction(random_instruction());
		// pc and A after the last instruction
		@(negedge clock);
		check_value("pc", pc, model_pc);
		check_value("address_m", address_m, model_a);
		check_jump_coverage();
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== common/hack_pkg.sv ====
`default_nettype none

`include "hack_settings.svh"

package hack_pkg;

	// Words, addresses and instruction fields
	typedef logic [`HACK_WORD_BITS-1:0] hack_word_t;
	typedef logic [`HACK_RAM_ADDR_BITS-1:0] hack_ram_addr_t;
	typedef logic [`HACK_COMP_HI-`HACK_COMP_LO:0] hack_comp_t;
	typedef logic [`HACK_DEST_HI-`HACK_DEST_LO:0] hack_dest_t;
	typedef logic [`HACK_JUMP_HI-`HACK_JUMP_LO:0] hack_jump_t;

	// Bit positions inside comp
	localparam int COMP_ZX = 5;
	localparam int COMP_NX = 4;
	localparam int COMP_ZY = 3;
	localparam int COMP_NY = 2;
	localparam int COMP_F = 1;
	localparam int COMP_NO = 0;

	// Bit positions inside dest, high to low A D M
	localparam int DEST_A = 2;
	localparam int DEST_D = 1;
	localparam int DEST_M = 0;

	// Jump codes
	localparam hack_jump_t JMP_NULL = 3'b000;
	localparam hack_jump_t JMP_JGT = 3'b001;
	localparam hack_jump_t JMP_JEQ = 3'b010;
	localparam hack_jump_t JMP_JGE = 3'b011;
	localparam hack_jump_t JMP_JLT = 3'b100;
	localparam hack_jump_t JMP_JNE = 3'b101;
	localparam hack_jump_t JMP_JLE = 3'b110;
	localparam hack_jump_t JMP_JMP = 3'b111;

endpackage

`default_nettype wire

// ==== common/hack_settings.svh ====
`ifndef HACK_SETTINGS_SVH
`define HACK_SETTINGS_SVH

////////////////////
// Datapath widths
////////////////////
`define HACK_WORD_BITS 16
`define HACK_RAM_ADDR_BITS 11

////////////////////
// Instruction field positions
////////////////////
`define HACK_TYPE_BIT 15
`define HACK_IMM_BITS 15
`define HACK_A_BIT 12
`define HACK_COMP_HI 11
`define HACK_COMP_LO 6
`define HACK_DEST_HI 5
`define HACK_DEST_LO 3
`define HACK_JUMP_HI 2
`define HACK_JUMP_LO 0

`endif

// ==== cpu/hack_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hack_settings.svh"

module hack_alu (
	input  hack_pkg::hack_word_t x,
	input  hack_pkg::hack_word_t y,
	input  hack_pkg::hack_comp_t comp,
	output hack_pkg::hack_word_t result,
	output logic zr,
	output logic ng
);

	import hack_pkg::*;

	hack_word_t x_zero, x_neg;
	hack_word_t y_zero, y_neg;
	hack_word_t f_out;

	// Operand conditioning then function then output inversion
	always_comb begin
		x_zero = comp[COMP_ZX] ? '0 : x;
		x_neg = comp[COMP_NX] ? ~x_zero : x_zero;
		y_zero = comp[COMP_ZY] ? '0 : y;
		y_neg = comp[COMP_NY] ? ~y_zero : y_zero;
		// Sum wraps modulo 2^16
		f_out = comp[COMP_F] ? (x_neg + y_neg) : (x_neg & y_neg);
		result = comp[COMP_NO] ? ~f_out : f_out;
	end

	// Flags from the final result
	assign zr = (result == '0);
	assign ng = result[`HACK_WORD_BITS-1];

	// Zero and negative are exclusive
	always_comb begin
		assert (!(zr && ng))
		else $error("hack_alu: zr and ng both high, result %h", result);
	end

endmodule

`default_nettype wire

// ==== cpu/hack_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hack_settings.svh"

module hack_cpu (
	input  logic clock,
	input  logic rst_n,
	input  hack_pkg::hack_word_t instruction,
	input  hack_pkg::hack_word_t in_m,
	output hack_pkg::hack_word_t out_m,
	output logic write_m,
	output hack_pkg::hack_word_t address_m,
	output hack_pkg::hack_word_t pc
);

	import hack_pkg::*;

	////////////////////
	// Instruction fields
	////////////////////
	logic c_instr;
	logic a_sel;
	hack_comp_t comp;
	hack_dest_t dest;
	hack_jump_t jump;

	assign c_instr = instruction[`HACK_TYPE_BIT];
	assign a_sel = instruction[`HACK_A_BIT];
	assign comp = instruction[`HACK_COMP_HI:`HACK_COMP_LO];
	assign dest = instruction[`HACK_DEST_HI:`HACK_DEST_LO];
	assign jump = instruction[`HACK_JUMP_HI:`HACK_JUMP_LO];

	hack_word_t a_reg, d_reg;
	hack_word_t y_operand, alu_result;
	logic zr, ng;
	logic pc_load, pc_inc;

	hack_registers u_registers (.clock(clock), .rst_n(rst_n), .instruction(instruction),
		.alu_result(alu_result), .a_reg(a_reg), .d_reg(d_reg));

	// y is A or the memory word addressed by A
	assign y_operand = a_sel ? in_m : a_reg;

	hack_alu u_alu (.x(d_reg), .y(y_operand), .comp(comp), .result(alu_result),
		.zr(zr), .ng(ng));

	hack_jump_unit u_jump_unit (.c_instr(c_instr), .jump(jump), .zr(zr), .ng(ng),
		.pc_load(pc_load), .pc_inc(pc_inc));

	// Jump target is A before this edge
	hack_program_counter u_program_counter (.clock(clock), .rst_n(rst_n),
		.target(a_reg), .load(pc_load), .inc(pc_inc), .pc(pc));

	////////////////////
	// Memory side
	////////////////////
	// Held low in reset so the RAM is not written
	assign write_m = rst_n && c_instr && dest[DEST_M];
	assign out_m = write_m ? alu_result : '0;
	assign address_m = a_reg;

endmodule

`default_nettype wire

// ==== cpu/hack_jump_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hack_jump_unit (
	input  logic c_instr,
	input  hack_pkg::hack_jump_t jump,
	input  logic zr,
	input  logic ng,
	output logic pc_load,
	output logic pc_inc
);

	import hack_pkg::*;

	logic taken;
	logic positive;

	assign positive = !zr && !ng;

	// Condition per jump code
	always_comb begin
		case (jump)
			JMP_JGT: taken = positive;
			JMP_JEQ: taken = zr;
			JMP_JGE: taken = !ng;
			JMP_JLT: taken = ng;
			JMP_JNE: taken = !zr;
			JMP_JLE: taken = zr || ng;
			JMP_JMP: taken = 1'b1;
			JMP_NULL: taken = 1'b0;
			default: taken = 1'b0;
		endcase
	end

	// A-instructions never jump
	assign pc_load = c_instr && taken;
	assign pc_inc = !c_instr || !taken;

	always_comb begin
		assert (!(pc_load && pc_inc))
		else $error("hack_jump_unit: load and increment both high");
	end

endmodule

`default_nettype wire

// ==== cpu/hack_program_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module hack_program_counter (
	input  logic clock,
	input  logic rst_n,
	input  hack_pkg::hack_word_t target,
	input  logic load,
	input  logic inc,
	output hack_pkg::hack_word_t pc
);

	import hack_pkg::*;

	hack_word_t pc_q;

	// Load wins over increment, increment wraps
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			pc_q <= '0;
		end else if (load) begin
			pc_q <= target;
		end else if (inc) begin
			pc_q <= pc_q + 1'b1;
		end
	end

	assign pc = pc_q;

endmodule

`default_nettype wire

// ==== cpu/hack_registers.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hack_settings.svh"

module hack_registers (
	input  logic clock,
	input  logic rst_n,
	input  hack_pkg::hack_word_t instruction,
	input  hack_pkg::hack_word_t alu_result,
	output hack_pkg::hack_word_t a_reg,
	output hack_pkg::hack_word_t d_reg
);

	import hack_pkg::*;

	logic c_instr;
	hack_dest_t dest;
	hack_word_t immediate;

	assign c_instr = instruction[`HACK_TYPE_BIT];
	assign dest = instruction[`HACK_DEST_HI:`HACK_DEST_LO];
	// Zero extended A-instruction constant
	assign immediate = {1'b0, instruction[`HACK_IMM_BITS-1:0]};

	////////////////////
	// A and D
	////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			a_reg <= '0;
			d_reg <= '0;
		end else begin
			if (!c_instr) begin
				a_reg <= immediate;
			end else if (dest[DEST_A]) begin
				a_reg <= alu_result;
			end
			if (c_instr && dest[DEST_D]) begin
				d_reg <= alu_result;
			end
		end
	end

	// An A-instruction never leaves a value with the top bit set in A
	a_imm_top_clear: assert property (@(posedge clock) disable iff (!rst_n)
		!c_instr |=> !a_reg[`HACK_WORD_BITS-1])
	else $error("hack_registers: A loaded from A-instruction with bit 15 set");

endmodule

`default_nettype wire

// ==== hack_computer.f ====
+incdir+common
+incdir+bench
common/hack_pkg.sv
cpu/hack_alu.sv
cpu/hack_jump_unit.sv
cpu/hack_program_counter.sv
cpu/hack_registers.sv
cpu/hack_cpu.sv
verilog/hack_data_memory.sv
verilog/hack_computer.sv
bench/hack_computer_tb.sv

// ==== verilog/hack_computer.sv ====
`timescale 1ns/1ps
`default_nettype none

module hack_computer (
	input  logic clock,
	input  logic rst_n,
	input  hack_pkg::hack_word_t instruction,
	output hack_pkg::hack_word_t pc,
	output hack_pkg::hack_word_t out_m,
	output logic write_m,
	output hack_pkg::hack_word_t address_m
);

	import hack_pkg::*;

	// Read data back from RAM
	hack_word_t in_m;

	////////////////////
	// CPU
	////////////////////
	hack_cpu u_cpu (
		.clock(clock),
		.rst_n(rst_n),
		.instruction(instruction),
		.in_m(in_m),
		.out_m(out_m),
		.write_m(write_m),
		.address_m(address_m),
		.pc(pc)
	);

	////////////////////
	// Data RAM
	////////////////////
	hack_data_memory u_data_memory (
		.clock(clock),
		.address(address_m),
		.write_data(out_m),
		.write(write_m),
		.read_data(in_m)
	);

endmodule

`default_nettype wire

// ==== verilog/hack_data_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hack_settings.svh"

module hack_data_memory (
	input  logic clock,
	input  hack_pkg::hack_word_t address,
	input  hack_pkg::hack_word_t write_data,
	input  logic write,
	output hack_pkg::hack_word_t read_data
);

	import hack_pkg::*;

	localparam int DEPTH = 1 << `HACK_RAM_ADDR_BITS;

	hack_word_t mem [DEPTH];
	hack_ram_addr_t index;

	// Low bits only, upper addresses wrap
	assign index = address[`HACK_RAM_ADDR_BITS-1:0];

	// Combinational read
	assign read_data = mem[index];

	always_ff @(posedge clock) begin
		if (write) begin
			mem[index] <= write_data;
		end
	end

	// No write to an unknown location
	addr_known_on_write: assert property (@(posedge clock)
		write |-> !$isunknown(address))
	else $error("hack_data_memory: write with unknown address %h", address);

endmodule

`default_nettype wire
